// File: Bender.yml
package:
  name: issue_core

sources:
  - logic/procyon_isa_pkg.sv
  - logic/procyon_core_pkg.sv
  - logic/dispatch.sv
  - logic/reservation_station.sv
  - logic/ieu.sv
  - logic/issue_core.sv
  - target: test
    files:
      - test/issue_core_assert.sv
      - test/issue_core_tb.sv

// File: build.f
logic/procyon_isa_pkg.sv
logic/procyon_core_pkg.sv
logic/dispatch.sv
logic/reservation_station.sv
logic/ieu.sv
logic/issue_core.sv
test/issue_core_assert.sv
test/issue_core_tb.sv

// File: logic/dispatch.sv
`timescale 1ns/10ps

module dispatch
    import procyon_isa_pkg::*;
    import procyon_core_pkg::*;
(
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_flush,
    input  procyon_dispatch_t i_dispatch,
    input  logic              i_rs_stall,
    output logic              o_dispatch_stall,
    output logic              o_rs_enq_en,
    output procyon_rs_entry_t o_rs_entry
);

    procyon_dispatch_t dispatch_q;
    procyon_insn_t     insn;
    procyon_src_t      imm_src;

    assign o_dispatch_stall = i_rs_stall;
    assign o_rs_enq_en      = dispatch_q.valid;

    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            dispatch_q.valid <= 1'b0;
        end else if (!i_rs_stall) begin
            dispatch_q.valid <= i_dispatch.valid;
        end

        // Held while the station is full
        if (!i_rs_stall) begin
            dispatch_q.insn    <= i_dispatch.insn;
            dispatch_q.dst_tag <= i_dispatch.dst_tag;
            dispatch_q.src_a   <= i_dispatch.src_a;
            dispatch_q.src_b   <= i_dispatch.src_b;
        end
    end

    assign insn    = dispatch_q.insn;
    assign imm_src = '{rdy: 1'b1, tag: '0,
                       data: {{(DATA_WIDTH-12){insn.itype.imm[11]}}, insn.itype.imm}};

    always_comb begin
        o_rs_entry.dst_tag = dispatch_q.dst_tag;
        o_rs_entry.src_a   = dispatch_q.src_a;
        o_rs_entry.src_b   = dispatch_q.src_b;
        o_rs_entry.alu_op  = ALU_ADD;

        case (insn.rtype.opcode)
            OPC_OP: begin
                case (insn.rtype.funct3)
                    F3_ADD_SUB: begin
                        if (insn.rtype.funct7 == F7_SUB) begin
                            o_rs_entry.alu_op = ALU_SUB;
                        end
                    end
                    F3_SLL:  o_rs_entry.alu_op = ALU_SLL;
                    F3_SLT:  o_rs_entry.alu_op = ALU_SLT;
                    F3_XOR:  o_rs_entry.alu_op = ALU_XOR;
                    F3_SRL:  o_rs_entry.alu_op = ALU_SRL;
                    F3_OR:   o_rs_entry.alu_op = ALU_OR;
                    F3_AND:  o_rs_entry.alu_op = ALU_AND;
                    default: o_rs_entry.alu_op = ALU_ADD;
                endcase
            end
            OPC_OPIMM: begin
                o_rs_entry.src_b = imm_src;
                case (insn.itype.funct3)
                    F3_XOR:  o_rs_entry.alu_op = ALU_XOR;
                    F3_OR:   o_rs_entry.alu_op = ALU_OR;
                    F3_AND:  o_rs_entry.alu_op = ALU_AND;
                    default: o_rs_entry.alu_op = ALU_ADD;
                endcase
            end
            default: o_rs_entry.alu_op = ALU_ADD;
        endcase
    end

endmodule

// File: logic/ieu.sv
`timescale 1ns/10ps

module ieu
    import procyon_isa_pkg::*;
    import procyon_core_pkg::*;
(
    input  logic           clk,
    input  logic           i_reset,
    input  logic           i_flush,
    input  procyon_fu_op_t i_fu_op,
    output procyon_cdb_t   o_cdb
);

    procyon_data_t alu_result;
    logic [4:0]    shamt;
    procyon_cdb_t  ex_q;

    // Shift amount is the low five bits only
    assign shamt = i_fu_op.b[4:0];

    always_comb begin
        case (i_fu_op.alu_op)
            ALU_ADD: alu_result = i_fu_op.a + i_fu_op.b;
            ALU_SUB: alu_result = i_fu_op.a - i_fu_op.b;
            ALU_AND: alu_result = i_fu_op.a & i_fu_op.b;
            ALU_OR:  alu_result = i_fu_op.a | i_fu_op.b;
            ALU_XOR: alu_result = i_fu_op.a ^ i_fu_op.b;
            ALU_SLT: alu_result = procyon_data_t'($signed(i_fu_op.a) < $signed(i_fu_op.b));
            ALU_SLL: alu_result = i_fu_op.a << shamt;
            ALU_SRL: alu_result = i_fu_op.a >> shamt;
            default: alu_result = '0;
        endcase
    end

    // Stage one
    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            ex_q.en <= 1'b0;
        end else begin
            ex_q.en <= i_fu_op.valid;
        end
        ex_q.tag  <= i_fu_op.dst_tag;
        ex_q.data <= alu_result;
    end

    // Stage two drives the broadcast
    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            o_cdb.en <= 1'b0;
        end else begin
            o_cdb.en <= ex_q.en;
        end
        o_cdb.tag  <= ex_q.tag;
        o_cdb.data <= ex_q.data;
    end

endmodule

// File: logic/issue_core.sv
`timescale 1ns/10ps

module issue_core
    import procyon_core_pkg::*;
#(
    parameter int RS_DEPTH = 4
) (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_flush,
    input  procyon_dispatch_t i_dispatch,
    output logic              o_dispatch_stall,
    output procyon_cdb_t      o_cdb
);

    logic              rs_stall;
    logic              rs_enq_en;
    procyon_rs_entry_t rs_enq_entry;
    procyon_fu_op_t    fu_op;
    procyon_cdb_t      cdb;

    // Results loop back into the station
    assign o_cdb = cdb;

    dispatch dispatch_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_flush(i_flush),
        .i_dispatch(i_dispatch),
        .i_rs_stall(rs_stall),
        .o_dispatch_stall(o_dispatch_stall),
        .o_rs_enq_en(rs_enq_en),
        .o_rs_entry(rs_enq_entry)
    );

    reservation_station #(
        .RS_DEPTH(RS_DEPTH)
    ) rs_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_flush(i_flush),
        .i_enq_en(rs_enq_en),
        .i_enq_entry(rs_enq_entry),
        .i_cdb(cdb),
        .o_rs_stall(rs_stall),
        .o_fu_op(fu_op)
    );

    ieu ieu_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_flush(i_flush),
        .i_fu_op(fu_op),
        .o_cdb(cdb)
    );

endmodule

// File: logic/procyon_core_pkg.sv
package procyon_core_pkg;

    import procyon_isa_pkg::*;

    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH  = 4;

    typedef logic [DATA_WIDTH-1:0] procyon_data_t;
    typedef logic [TAG_WIDTH-1:0]  procyon_tag_t;

    // Operand value, or the tag it waits on while rdy is low
    typedef struct packed {
        logic            rdy;
        procyon_tag_t    tag;
        procyon_data_t   data;
    } procyon_src_t;

    typedef struct packed {
        logic            valid;
        procyon_insn_t   insn;
        procyon_tag_t    dst_tag;
        procyon_src_t    src_a;
        procyon_src_t    src_b;
    } procyon_dispatch_t;

    typedef struct packed {
        procyon_alu_op_t alu_op;
        procyon_tag_t    dst_tag;
        procyon_src_t    src_a;
        procyon_src_t    src_b;
    } procyon_rs_entry_t;

    typedef struct packed {
        logic            valid;
        procyon_alu_op_t alu_op;
        procyon_tag_t    dst_tag;
        procyon_data_t   a;
        procyon_data_t   b;
    } procyon_fu_op_t;

    typedef struct packed {
        logic            en;
        procyon_tag_t    tag;
        procyon_data_t   data;
    } procyon_cdb_t;

endpackage

// File: logic/procyon_isa_pkg.sv
package procyon_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Bit 30 set selects SUB over ADD
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    typedef struct packed {
        logic [6:0]  funct7;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } procyon_rtype_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } procyon_itype_t;

    // Same 32-bit word, two views
    typedef union packed {
        procyon_rtype_t rtype;
        procyon_itype_t itype;
    } procyon_insn_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } procyon_alu_op_t;

endpackage

// File: logic/reservation_station.sv
`timescale 1ns/10ps

module reservation_station
    import procyon_core_pkg::*;
#(
    parameter int RS_DEPTH = 4
) (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_flush,
    input  logic              i_enq_en,
    input  procyon_rs_entry_t i_enq_entry,
    input  procyon_cdb_t      i_cdb,
    output logic              o_rs_stall,
    output procyon_fu_op_t    o_fu_op
);

    localparam int AGE_WIDTH = $clog2(RS_DEPTH);

    typedef logic [AGE_WIDTH-1:0] age_t;

    logic [RS_DEPTH-1:0] entry_valid;
    age_t                entry_age [RS_DEPTH];
    procyon_rs_entry_t   entries   [RS_DEPTH];

    logic                rs_full;
    logic                enq_accept;
    logic [RS_DEPTH-1:0] enq_select;
    procyon_rs_entry_t   enq_entry;

    logic [RS_DEPTH-1:0] entry_rdy;
    logic                issue_en;
    logic [RS_DEPTH-1:0] issue_select;
    age_t                issue_age;
    procyon_rs_entry_t   issue_entry;

    function automatic procyon_src_t cdb_capture(procyon_src_t src, procyon_cdb_t cdb);
        procyon_src_t result;
        result = src;
        if (!src.rdy && cdb.en && (cdb.tag == src.tag)) begin
            result.rdy  = 1'b1;
            result.data = cdb.data;
        end
        return result;
    endfunction

    assign rs_full    = &entry_valid;
    assign o_rs_stall = rs_full;
    assign enq_accept = i_enq_en && !rs_full;

    // Incoming entry also snoops the bus
    always_comb begin
        enq_entry       = i_enq_entry;
        enq_entry.src_a = cdb_capture(i_enq_entry.src_a, i_cdb);
        enq_entry.src_b = cdb_capture(i_enq_entry.src_b, i_cdb);
    end

    // Lowest free slot
    always_comb begin
        enq_select = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!entry_valid[i] && (enq_select == '0)) begin
                enq_select[i] = 1'b1;
            end
        end
    end

    // Oldest ready entry has the highest age
    always_comb begin
        issue_en     = 1'b0;
        issue_select = '0;
        issue_age    = '0;
        issue_entry  = entries[0];
        for (int i = 0; i < RS_DEPTH; i++) begin
            entry_rdy[i] = entry_valid[i] && entries[i].src_a.rdy && entries[i].src_b.rdy;
            if (entry_rdy[i] && (!issue_en || (entry_age[i] > issue_age))) begin
                issue_en        = 1'b1;
                issue_age       = entry_age[i];
                issue_select    = '0;
                issue_select[i] = 1'b1;
                issue_entry     = entries[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            entry_valid <= '0;
        end else begin
            entry_valid <= (entry_valid & ~issue_select) | (enq_accept ? enq_select : '0);
        end
    end

    // Ages stay a dense 0..n-1 ordering of the valid entries
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (i_reset) begin
                entry_age[i] <= '0;
            end else if (enq_accept && enq_select[i]) begin
                entry_age[i] <= '0;
            end else if (entry_valid[i]) begin
                entry_age[i] <= entry_age[i] + age_t'(enq_accept)
                                - age_t'(issue_en && (entry_age[i] > issue_age));
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (enq_accept && enq_select[i]) begin
                entries[i] <= enq_entry;
            end else begin
                entries[i].src_a <= cdb_capture(entries[i].src_a, i_cdb);
                entries[i].src_b <= cdb_capture(entries[i].src_b, i_cdb);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            o_fu_op.valid <= 1'b0;
        end else begin
            o_fu_op.valid <= issue_en;
        end
        o_fu_op.alu_op  <= issue_entry.alu_op;
        o_fu_op.dst_tag <= issue_entry.dst_tag;
        o_fu_op.a       <= issue_entry.src_a.data;
        o_fu_op.b       <= issue_entry.src_b.data;
    end

endmodule

// File: test/issue_core_assert.sv
`timescale 1ns/10ps

module issue_core_assert
    import procyon_core_pkg::*;
#(
    parameter int RS_DEPTH = 4
) (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_flush,
    input  logic [RS_DEPTH-1:0] i_entry_valid,
    input  logic                i_rs_full,
    input  procyon_fu_op_t      i_fu_op,
    input  procyon_cdb_t        i_cdb
);

    // A full station allocates no new slot on the next edge
    no_enq_when_full: assert property (
        @(posedge clk) disable iff (i_reset)
        i_rs_full |=> ((i_entry_valid & ~$past(i_entry_valid)) == '0)
    ) else $error("enqueue accepted while station full");

    // Bus goes quiet one cycle after reset or flush
    cdb_quiet: assert property (
        @(posedge clk) (i_reset || i_flush) |=> !i_cdb.en
    ) else $error("CDB active after reset or flush");

    single_issue: assert property (
        @(posedge clk) disable iff (i_reset)
        i_fu_op.valid |=> !(i_fu_op.valid && i_fu_op.dst_tag == $past(i_fu_op.dst_tag))
    ) else $error("same tag issued twice");

endmodule

bind reservation_station issue_core_assert #(.RS_DEPTH(RS_DEPTH)) rs_assert_inst (
    .clk(clk),
    .i_reset(i_reset),
    .i_flush(i_flush),
    .i_entry_valid(entry_valid),
    .i_rs_full(o_rs_stall),
    .i_fu_op(o_fu_op),
    .i_cdb(i_cdb)
);

// File: test/issue_core_tb.sv
`timescale 1ns/10ps

module issue_core_tb
    import procyon_isa_pkg::*;
    import procyon_core_pkg::*;
;

    localparam int RS_DEPTH   = 4;
    localparam int NUM_ROWS   = 27;
    localparam int CLK_PERIOD = 40;

    typedef struct {
        int          phase;
        logic [31:0] insn;
        logic [3:0]  tag;
        logic        a_dep;
        logic [3:0]  a_tag;
        logic [31:0] a_data;
        logic [31:0] b_data;
        logic        kill;
        logic        flush_after;
        logic [31:0] exp;
    } row_t;

    logic              clk;
    logic              i_reset;
    logic              i_flush;
    procyon_dispatch_t i_dispatch;
    logic              o_dispatch_stall;
    procyon_cdb_t      o_cdb;

    row_t        rows [NUM_ROWS];
    int          num_rows = 0;
    integer      seed = 86404;
    logic [31:0] model [16];
    logic        pending [16];
    logic [31:0] exp_val [16];
    logic        stall_seen = 1'b0;
    int          value_errors = 0;
    int          other_errors = 0;

    issue_core #(.RS_DEPTH(RS_DEPTH)) DUT (
        .clk(clk),
        .i_reset(i_reset),
        .i_flush(i_flush),
        .i_dispatch(i_dispatch),
        .o_dispatch_stall(o_dispatch_stall),
        .o_cdb(o_cdb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // I-type takes the sign-extended immediate as b
    function automatic logic [31:0] ref_result(logic [31:0] insn, logic [31:0] a,
                                               logic [31:0] b);
        logic [31:0] op_b;
        logic        is_imm;
        is_imm = (insn[6:0] == 7'b0010011);
        op_b   = is_imm ? {{20{insn[31]}}, insn[31:20]} : b;
        case (insn[14:12])
            3'b000:  ref_result = (!is_imm && insn[30]) ? a - op_b : a + op_b;
            3'b001:  ref_result = a << op_b[4:0];
            3'b010:  ref_result = {31'b0, $signed(a) < $signed(op_b)};
            3'b100:  ref_result = a ^ op_b;
            3'b101:  ref_result = a >> op_b[4:0];
            3'b110:  ref_result = a | op_b;
            default: ref_result = a & op_b;
        endcase
    endfunction

    function automatic logic [31:0] r_insn(logic [6:0] f7, logic [2:0] f3);
        r_insn = {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_insn(logic [11:0] imm, logic [2:0] f3);
        i_insn = {imm, 5'd1, f3, 5'd3, 7'b0010011};
    endfunction

    task automatic add_row(input int phase, input logic [31:0] insn, input logic [3:0] tag,
                           input logic a_dep, input logic [3:0] a_tag,
                           input logic kill, input logic flush_after);
        row_t        r;
        logic [31:0] a;
        r.phase       = phase;
        r.insn        = insn;
        r.tag         = tag;
        r.a_dep       = a_dep;
        r.a_tag       = a_tag;
        r.a_data      = $random(seed);
        r.b_data      = $random(seed);
        r.kill        = kill;
        r.flush_after = flush_after;
        a             = a_dep ? model[a_tag] : r.a_data;
        r.exp         = ref_result(insn, a, r.b_data);
        model[tag]    = r.exp;
        rows[num_rows] = r;
        num_rows++;
    endtask

    task automatic build_table();
        // Independent R-type
        add_row(0, r_insn(7'h00, 3'b000), 4'd0, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(0, r_insn(7'h20, 3'b000), 4'd1, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(0, r_insn(7'h00, 3'b111), 4'd2, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(0, r_insn(7'h00, 3'b110), 4'd3, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(0, r_insn(7'h00, 3'b100), 4'd4, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(0, r_insn(7'h00, 3'b010), 4'd5, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(0, r_insn(7'h00, 3'b001), 4'd6, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(0, r_insn(7'h00, 3'b101), 4'd7, 1'b0, 4'd0, 1'b0, 1'b0);
        // Immediates with three negative values
        add_row(1, i_insn(12'hffb, 3'b000), 4'd8, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(1, i_insn(12'h0f0, 3'b111), 4'd9, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(1, i_insn(12'h800, 3'b110), 4'd10, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(1, i_insn(12'hfff, 3'b100), 4'd11, 1'b0, 4'd0, 1'b0, 1'b0);
        // Forwarding chain
        add_row(2, r_insn(7'h00, 3'b000), 4'd0, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(2, r_insn(7'h20, 3'b000), 4'd1, 1'b1, 4'd0, 1'b0, 1'b0);
        add_row(2, r_insn(7'h00, 3'b100), 4'd2, 1'b1, 4'd1, 1'b0, 1'b0);
        add_row(2, r_insn(7'h00, 3'b001), 4'd3, 1'b1, 4'd2, 1'b0, 1'b0);
        // Waiters on tag 6 fill the station
        add_row(3, r_insn(7'h00, 3'b000), 4'd4, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(3, r_insn(7'h00, 3'b110), 4'd5, 1'b1, 4'd4, 1'b0, 1'b0);
        add_row(3, i_insn(12'h123, 3'b000), 4'd6, 1'b1, 4'd5, 1'b0, 1'b0);
        add_row(3, r_insn(7'h00, 3'b000), 4'd7, 1'b1, 4'd6, 1'b0, 1'b0);
        add_row(3, r_insn(7'h20, 3'b000), 4'd8, 1'b1, 4'd6, 1'b0, 1'b0);
        add_row(3, r_insn(7'h00, 3'b010), 4'd9, 1'b1, 4'd6, 1'b0, 1'b0);
        add_row(3, r_insn(7'h00, 3'b101), 4'd10, 1'b1, 4'd6, 1'b0, 1'b0);
        // Tag 15 is produced only after the flush
        add_row(4, r_insn(7'h00, 3'b000), 4'd12, 1'b1, 4'd15, 1'b1, 1'b0);
        add_row(4, r_insn(7'h00, 3'b100), 4'd13, 1'b1, 4'd15, 1'b1, 1'b1);
        add_row(5, i_insn(12'hf80, 3'b000), 4'd14, 1'b0, 4'd0, 1'b0, 1'b0);
        add_row(5, r_insn(7'h00, 3'b110), 4'd15, 1'b0, 4'd0, 1'b0, 1'b0);
    endtask

    task automatic dispatch_row(input int i);
        i_dispatch.valid   = 1'b1;
        i_dispatch.insn    = rows[i].insn;
        i_dispatch.dst_tag = rows[i].tag;
        if (rows[i].a_dep) begin
            i_dispatch.src_a = '{rdy: 1'b0, tag: rows[i].a_tag, data: '0};
        end else begin
            i_dispatch.src_a = '{rdy: 1'b1, tag: '0, data: rows[i].a_data};
        end
        i_dispatch.src_b = '{rdy: 1'b1, tag: '0, data: rows[i].b_data};
        if (!rows[i].kill) begin
            pending[rows[i].tag] = 1'b1;
            exp_val[rows[i].tag] = rows[i].exp;
        end
        while (o_dispatch_stall) @(negedge clk);
        @(negedge clk);
        i_dispatch.valid = 1'b0;
        if (rows[i].flush_after) begin
            repeat (4) @(negedge clk);
            i_flush = 1'b1;
            @(negedge clk);
            i_flush = 1'b0;
        end
    endtask

    function automatic int pending_total();
        pending_total = 0;
        for (int t = 0; t < 16; t++) begin
            pending_total += pending[t];
        end
    endfunction

    task automatic wait_drain();
        while (pending_total() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    task automatic check_stall_phase(input int phase);
        if (phase == 3 && !stall_seen) begin
            $display("Station never stalled dispatch with %0d entries waiting", RS_DEPTH);
            other_errors++;
        end
    endtask

    // CDB outputs settle after the rising edge
    always @(negedge clk) begin
        if (o_dispatch_stall) begin
            stall_seen = 1'b1;
        end
        if (!i_reset && o_cdb.en) begin
            if (!pending[o_cdb.tag]) begin
                $display("%0t: tag %0d broadcast with no instruction waiting for it",
                         $time, o_cdb.tag);
                other_errors++;
            end else begin
                if (o_cdb.data !== exp_val[o_cdb.tag]) begin
                    $display("[FAIL] %0t o_cdb.data (tag %0d) expected %h actual %h",
                             $time, o_cdb.tag, exp_val[o_cdb.tag], o_cdb.data);
                    value_errors++;
                end
                pending[o_cdb.tag] = 1'b0;
            end
        end
    end

    initial begin
        #((NUM_ROWS * 20 + 16) * CLK_PERIOD);
        $display("Timeout with %0d results never seen on the CDB", pending_total());
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        i_reset    = 1'b1;
        i_flush    = 1'b0;
        i_dispatch = '0;
        for (int t = 0; t < 16; t++) begin
            pending[t] = 1'b0;
            model[t]   = '0;
        end
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;

        repeat (10) begin
            @(negedge clk);
            if (o_cdb.en || o_dispatch_stall) begin
                $display("CDB or stall active after reset with no input at %0t", $time);
                other_errors++;
            end
        end

        for (int i = 0; i < num_rows; i++) begin
            if (i > 0 && rows[i].phase != rows[i-1].phase) begin
                wait_drain();
                check_stall_phase(rows[i-1].phase);
            end
            dispatch_row(i);
        end
        wait_drain();
        repeat (10) @(negedge clk);

        $display("Errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
